/* logo_key_stimulus.txt */
// geometry: frames, hblank, active width, vblank lines, active lines
0004 0028 0040 0004 0008
// frame: mask (bits 0-4 regs, bit 5 mid write), mode, x0, y0, x1, y1, mid addr, mid data
003f 0001 0014 0001 002c 0007 0000 0000
0020 0000 0000 0000 0000 0000 0001 0008
0021 0001 0000 0000 0000 0000 0007 0000
0000 0000 0000 0000 0000 0000 0000 0000
// logo pixels as hi lo key
00ff00 01fe40 02fd80 03fcff 04fb20 05fac0 06f910 07f8e0
08f700 09f640 0af580 0bf4ff 0cf320 0df2c0 0ef110 0ff0e0
10ef00 11ee40 12ed80 13ecff 14eb20 15eac0 16e910 17e8e0
18e700 19e640 1ae580 1be4ff 1ce320 1de2c0 1ee110 1fe0e0
20df00 21de40 22dd80 23dcff 24db20 25dac0 26d910 27d8e0
28d700 29d640 2ad580 2bd4ff 2cd320 2dd2c0 2ed110 2fd0e0
30cf00 31ce40 32cd80 33ccff 34cb20 35cac0 36c910 37c8e0
38c700 39c640 3ac580 3bc4ff 3cc320 3dc2c0 3ec110 3fc0e0
40bf00 41be40 42bd80 43bcff 44bb20 45bac0 46b910 47b8e0
48b700 49b640 4ab580 4bb4ff 4cb320 4db2c0 4eb110 4fb0e0
50af00 51ae40 52ad80 53acff 54ab20 55aac0 56a910 57a8e0
58a700 59a640 5aa580 5ba4ff 5ca320 5da2c0 5ea110 5fa0e0
609f00 619e40 629d80 639cff 649b20 659ac0 669910 6798e0
689700 699640 6a9580 6b94ff 6c9320 6d92c0 6e9110 6f90e0
708f00 718e40 728d80 738cff 748b20 758ac0 768910 7788e0
788700 798640 7a8580 7b84ff 7c8320 7d82c0 7e8110 7f80e0
807f00 817e40 827d80 837cff 847b20 857ac0 867910 8778e0
887700 897640 8a7580 8b74ff 8c7320 8d72c0 8e7110 8f70e0
906f00 916e40 926d80 936cff 946b20 956ac0 966910 9768e0
986700 996640 9a6580 9b64ff 9c6320 9d62c0 9e6110 9f60e0
a05f00 a15e40 a25d80 a35cff a45b20 a55ac0 a65910 a758e0
a85700 a95640 aa5580 ab54ff ac5320 ad52c0 ae5110 af50e0
b04f00 b14e40 b24d80 b34cff b44b20 b54ac0 b64910 b748e0
b84700 b94640 ba4580 bb44ff bc4320 bd42c0 be4110 bf40e0

/* logo_key.f */
+incdir+.
logo_key_pkg.sv
raster_counter.sv
key_regs.sv
logo_fetch_fsm.sv
logo_buffer.sv
video_keyer.sv
logo_key.sv
tb_logo_key.sv

/* Makefile */
TOP = tb_logo_key

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f logo_key.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f logo_key.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir

/* tb_logo_key.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module tb_logo_key;

  import logo_key_pkg::*;

  localparam int LOGO_LEN = 2 * `LK_BUF_DEPTH;  // logo words before the memory wraps
  localparam int REC_BASE = 5;                  // first per-frame record
  localparam int REC_LEN  = 8;
  localparam int STIM_LEN = 5 + 4 * REC_LEN + LOGO_LEN;

  logic                  Pclk_Rx   = 1'b0;
  logic                  reset_n   = 1'b0;
  video_word_t           rx_data   = '0;
  hvf_t                  rx_hvf    = '0;
  logic                  reg_wr    = 1'b0;
  reg_addr_e             reg_addr  = REG_MODE;
  logic [`LK_REG_W-1:0]  reg_data  = '0;
  logic                  mem_valid = 1'b0;
  logo_pixel_t           mem_pixel = '0;
  video_word_t           tx_data;
  hvf_t                  tx_hvf;
  logic                  fetch_req;
  logic                  fetch_restart;

  logic [31:0] stim [0:STIM_LEN-1];
  logo_pixel_t logo_mem [0:LOGO_LEN-1];
  int          num_frames;
  int          hblank;
  int          line_len;
  int          vb_lines;
  int          act_lines;
  longint      limit_ns = 0;

  // reference model state
  int          m_x = 0;
  int          m_y = 0;
  logic        m_hd = 1'b0;
  logic        m_vd = 1'b0;
  window_t     win_pend = '0;
  window_t     win_act = '0;
  logic        en_pend = 1'b0;
  logic        en_act = 1'b0;
  int          n_pix = 0;
  int          frames_seen = 0;
  string       tname = "reset";
  video_word_t exp_video [$];
  hvf_t        exp_hvf [$];
  string       exp_name [$];

  // memory model
  logic [15:0] mem_lfsr = 16'd46;
  logic [15:0] vid_lfsr = 16'd46;
  logic        mem_busy = 1'b0;
  int          mem_left = 0;
  int          mem_addr = 0;
  int          restart_cnt = 0;
  logic [31:0] gap_bit;

  logo_key u_logo_key (
    .Pclk_Rx       (Pclk_Rx),
    .reset_n       (reset_n),
    .rx_data       (rx_data),
    .rx_hvf        (rx_hvf),
    .reg_wr        (reg_wr),
    .reg_addr      (reg_addr),
    .reg_data      (reg_data),
    .mem_valid     (mem_valid),
    .mem_pixel     (mem_pixel),
    .tx_data       (tx_data),
    .tx_hvf        (tx_hvf),
    .fetch_req     (fetch_req),
    .fetch_restart (fetch_restart)
  );

  initial
  begin
    forever #50 Pclk_Rx = ~Pclk_Rx;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val = {val[30:0], st[0]};  // one step per bit
      st  = lfsr_step(st);
    end
  endtask

  function automatic logic [7:0] mix_byte(input int fg, input int bg, input int key);
    int acc;
    acc = fg * key + bg * (256 - key);
    return 8'(acc >> 8);
  endfunction

  task automatic check_video(input string name, input video_word_t exp,
                             input video_word_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s video expected %h actual %h", name, exp, act);
      stop_run("video output differs from the reference");
    end
  endtask

  task automatic check_hvf(input string name, input hvf_t exp, input hvf_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s hvf expected %b actual %b", name, exp, act);
      stop_run("timing output differs from the reference");
    end
  endtask

  // ------------------------------
  // reference model with one call per sampled input cycle
  // ------------------------------
  task automatic model_step();
    logic        fs;
    logic        inw;
    video_word_t e;
    logo_pixel_t lp;
    fs  = m_vd && !rx_hvf.v;
    inw = !rx_hvf.h && !rx_hvf.v
          && m_x >= win_act.x_start && m_x < win_act.x_end
          && m_y >= win_act.y_start && m_y < win_act.y_end;
    e = rx_data;
    if (inw && en_act)
    begin
      lp   = logo_mem[n_pix % LOGO_LEN];  // n-th window pixel gets logo word n
      e.hi = {mix_byte(lp.hi, rx_data.hi[9:2], lp.key), 2'b11};
      e.lo = {mix_byte(lp.lo, rx_data.lo[9:2], lp.key), 2'b11};
    end
    exp_video.push_back(e);
    exp_hvf.push_back(rx_hvf);
    exp_name.push_back(tname);
    if (inw)
      n_pix++;
    if (rx_hvf.h && !m_hd)
      m_y = rx_hvf.v ? 0 : m_y + 1;
    m_x  = rx_hvf.h ? 0 : m_x + 1;
    m_hd = rx_hvf.h;
    m_vd = rx_hvf.v;
    if (fs)
    begin
      if (restart_cnt != frames_seen)
        stop_run("memory saw a wrong number of restart requests in the last frame");
      win_act = win_pend;
      en_act  = en_pend;
      n_pix   = 0;
      frames_seen++;
    end
    if (reg_wr)
    begin
      case (reg_addr)
        REG_MODE:    en_pend = reg_data[0];
        REG_X_START: win_pend.x_start = reg_data[`LK_X_W-1:0];
        REG_Y_START: win_pend.y_start = reg_data[`LK_Y_W-1:0];
        REG_X_END:   win_pend.x_end = reg_data[`LK_X_W-1:0];
        REG_Y_END:   win_pend.y_end = reg_data[`LK_Y_W-1:0];
        default: ;
      endcase
    end
  endtask

  task automatic apply_cycle(input logic h, input logic v, input logic f, input logic wr,
                             input reg_addr_e addr, input logic [15:0] data);
    logic [31:0] bits;
    take_bits(vid_lfsr, 20, bits);
    rx_data  <= video_word_t'(bits[19:0]);
    rx_hvf   <= {f, v, h};
    reg_wr   <= wr;
    reg_addr <= addr;
    reg_data <= data;
    @(posedge Pclk_Rx);
    model_step();
  endtask

  // outputs settle after the edge and are checked two cycles behind the inputs
  always @(negedge Pclk_Rx)
  begin
    if (reset_n && exp_video.size() >= `LK_PIPE)
    begin
      check_hvf(exp_name[0], exp_hvf.pop_front(), tx_hvf);
      check_video(exp_name.pop_front(), exp_video.pop_front(), tx_data);
    end
  end

  // ------------------------------
  // logo memory with 48 words per request and random gaps
  // ------------------------------
  always @(posedge Pclk_Rx)
  begin
    if (reset_n)
    begin
      if (fetch_req)
      begin
        if (mem_busy)
          stop_run("fetch request arrived while the memory was mid-burst");
        mem_busy = 1'b1;
        mem_left = `LK_HALF;
        if (fetch_restart)
        begin
          mem_addr = 0;
          restart_cnt++;
        end
      end
      mem_valid <= 1'b0;
      if (mem_busy)
      begin
        take_bits(mem_lfsr, 1, gap_bit);
        if (gap_bit[0] == 1'b0)
        begin
          mem_valid <= 1'b1;
          mem_pixel <= logo_mem[mem_addr];
          mem_addr  = (mem_addr + 1) % LOGO_LEN;
          mem_left--;
          if (mem_left == 0)
            mem_busy = 1'b0;
        end
      end
    end
  end

  initial
  begin
    wait (limit_ns > 0);
    #(limit_ns);
    stop_run("timeout, the run did not finish in time");
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    int rec;
    logic [31:0] mask;
    $readmemh("logo_key_stimulus.txt", stim);
    num_frames = int'(stim[0]);
    hblank     = int'(stim[1]);
    line_len   = hblank + int'(stim[2]);
    vb_lines   = int'(stim[3]);
    act_lines  = int'(stim[4]);
    for (int i = 0; i < LOGO_LEN; i++)
      logo_mem[i] = logo_pixel_t'(stim[REC_BASE + 4 * REC_LEN + i][23:0]);
    limit_ns = longint'((num_frames + 1) * (vb_lines + act_lines) * line_len + 500) * 100;

    repeat (3) @(posedge Pclk_Rx);
    reset_n <= 1'b1;

    for (int fr = 0; fr < num_frames; fr++)
    begin
      rec  = REC_BASE + fr * REC_LEN;
      mask = stim[rec];
      for (int ln = 0; ln < vb_lines; ln++)
      begin
        tname = $sformatf("frame %0d vblank %0d", fr, ln);
        for (int c = 0; c < line_len; c++)
        begin
          // register address c takes record word c+1 when its mask bit is set
          if (ln == 0 && c < 5 && mask[c])
            apply_cycle(c < hblank, 1'b1, fr[0], 1'b1, reg_addr_e'(c), stim[rec+1+c][15:0]);
          else
            apply_cycle(c < hblank, 1'b1, fr[0], 1'b0, REG_MODE, 16'h0);
        end
      end
      for (int ln = 0; ln < act_lines; ln++)
      begin
        tname = $sformatf("frame %0d line %0d", fr, ln);
        for (int c = 0; c < line_len; c++)
        begin
          if (ln == 2 && c == hblank + 10 && mask[5])  // mid-frame write
            apply_cycle(1'b0, 1'b0, fr[0], 1'b1, reg_addr_e'(stim[rec+6][3:0]),
                        stim[rec+7][15:0]);
          else
            apply_cycle(c < hblank, ln == 0 && c == 0, fr[0], 1'b0, REG_MODE, 16'h0);
        end
      end
    end
    tname = "trailing vblank";
    for (int c = 0; c < vb_lines * line_len; c++)
      apply_cycle(c % line_len < hblank, 1'b1, 1'b0, 1'b0, REG_MODE, 16'h0);

    if (restart_cnt != num_frames)
      stop_run("restart request count does not match the frame count");
    else
    begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* logo_key.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module logo_key (
  input  logic                      Pclk_Rx,
  input  logic                      reset_n,
  input  logo_key_pkg::video_word_t rx_data,
  input  logo_key_pkg::hvf_t        rx_hvf,
  input  logic                      reg_wr,
  input  logo_key_pkg::reg_addr_e   reg_addr,
  input  logic [`LK_REG_W-1:0]      reg_data,
  input  logic                      mem_valid,
  input  logo_key_pkg::logo_pixel_t mem_pixel,
  output logo_key_pkg::video_word_t tx_data,
  output logo_key_pkg::hvf_t        tx_hvf,
  output logic                      fetch_req,
  output logic                      fetch_restart
);

  import logo_key_pkg::*;

  window_t     window;
  logo_pixel_t logo_pixel;
  logic        frame_start;
  logic        in_window;
  logic        key_enable;
  logic        key_on;
  logic        refill_need;

  // ------------------------------
  // timing and registers
  // ------------------------------
  raster_counter u_raster_counter (
    .Pclk_Rx     (Pclk_Rx),
    .reset_n     (reset_n),
    .rx_hvf      (rx_hvf),
    .window      (window),
    .pos         (),
    .frame_start (frame_start),
    .in_window   (in_window)
  );

  key_regs u_key_regs (
    .Pclk_Rx     (Pclk_Rx),
    .reset_n     (reset_n),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_data    (reg_data),
    .frame_start (frame_start),
    .window      (window),
    .key_enable  (key_enable)
  );

  // ------------------------------
  // logo path
  // ------------------------------
  logo_fetch_fsm u_logo_fetch_fsm (
    .Pclk_Rx       (Pclk_Rx),
    .reset_n       (reset_n),
    .frame_start   (frame_start),
    .refill_need   (refill_need),
    .mem_valid     (mem_valid),
    .fetch_req     (fetch_req),
    .fetch_restart (fetch_restart)
  );

  logo_buffer u_logo_buffer (
    .Pclk_Rx     (Pclk_Rx),
    .reset_n     (reset_n),
    .frame_start (frame_start),
    .in_window   (in_window),
    .mem_valid   (mem_valid),
    .mem_pixel   (mem_pixel),
    .logo_pixel  (logo_pixel),
    .refill_need (refill_need)
  );

  assign key_on = in_window && key_enable;

  video_keyer u_video_keyer (
    .Pclk_Rx    (Pclk_Rx),
    .reset_n    (reset_n),
    .rx_data    (rx_data),
    .rx_hvf     (rx_hvf),
    .logo_pixel (logo_pixel),
    .key_on     (key_on),
    .tx_data    (tx_data),
    .tx_hvf     (tx_hvf)
  );

endmodule

/* video_keyer.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module video_keyer (
  input  logic                      Pclk_Rx,
  input  logic                      reset_n,
  input  logo_key_pkg::video_word_t rx_data,
  input  logo_key_pkg::hvf_t        rx_hvf,
  input  logo_key_pkg::logo_pixel_t logo_pixel,
  input  logic                      key_on,
  output logo_key_pkg::video_word_t tx_data,
  output logo_key_pkg::hvf_t        tx_hvf
);

  import logo_key_pkg::*;

  video_word_t s1_video;
  logo_pixel_t s1_logo;
  logic        s1_key_on;
  hvf_t        s1_hvf;

  // (fg * key + bg * (256 - key)) / 256
  function automatic logic [`LK_BYTE_W-1:0] blend8(input logic [7:0] fg,
                                                   input logic [7:0] bg,
                                                   input logic [7:0] key);
    logic [16:0] fg_term;
    logic [16:0] bg_term;
    logic [16:0] acc;
    fg_term = {9'd0, fg} * {9'd0, key};
    bg_term = {9'd0, bg} * (17'd256 - {9'd0, key});
    acc = fg_term + bg_term;
    return acc[15:8];
  endfunction

  always_ff @(posedge Pclk_Rx or negedge reset_n)
  begin
    if (!reset_n)
    begin
      s1_video  <= '0;
      s1_key_on <= 1'b0;
      s1_hvf    <= '0;
      tx_data   <= '0;
      tx_hvf    <= '0;
    end
    else
    begin
      // stage 1
      s1_video  <= rx_data;
      s1_key_on <= key_on;
      s1_hvf    <= rx_hvf;
      // stage 2, only the upper byte of each sample enters the blend
      if (s1_key_on)
      begin
        tx_data.hi <= {blend8(s1_logo.hi, s1_video.hi[9:2], s1_logo.key), 2'b11};
        tx_data.lo <= {blend8(s1_logo.lo, s1_video.lo[9:2], s1_logo.key), 2'b11};
      end
      else
        tx_data <= s1_video;
      tx_hvf <= s1_hvf;
    end
  end

  always_ff @(posedge Pclk_Rx)
  begin
    s1_logo <= logo_pixel;
  end

endmodule

/* logo_buffer.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module logo_buffer (
  input  logic                      Pclk_Rx,
  input  logic                      reset_n,
  input  logic                      frame_start,
  input  logic                      in_window,
  input  logic                      mem_valid,
  input  logo_key_pkg::logo_pixel_t mem_pixel,
  output logo_key_pkg::logo_pixel_t logo_pixel,
  output logic                      refill_need
);

  import logo_key_pkg::*;

  localparam int PTR_W = $clog2(`LK_BUF_DEPTH);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`LK_BUF_DEPTH - 1);
  localparam logic [PTR_W-1:0] HALF_LAST = PTR_W'(`LK_HALF - 1);

  logo_pixel_t      ring [`LK_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  always_ff @(posedge Pclk_Rx)
  begin
    if (mem_valid)
      ring[wr_ptr] <= mem_pixel;
  end

  assign logo_pixel = ring[rd_ptr];  // pixel for the current window clock

  // ------------------------------
  // pointers
  // ------------------------------
  always_ff @(posedge Pclk_Rx or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      refill_need <= 1'b0;
    end
    else if (frame_start)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      refill_need <= 1'b0;
    end
    else
    begin
      if (mem_valid)
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (in_window)
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      // the half just left may be overwritten now
      refill_need <= in_window && (rd_ptr == HALF_LAST || rd_ptr == LAST);
    end
  end

endmodule

/* logo_fetch_fsm.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module logo_fetch_fsm (
  input  logic Pclk_Rx,
  input  logic reset_n,
  input  logic frame_start,
  input  logic refill_need,
  input  logic mem_valid,
  output logic fetch_req,
  output logic fetch_restart
);

  import logo_key_pkg::*;

  fetch_state_e state;
  logic [5:0]   word_cnt;    // words returned in the current burst
  logic         pending;     // refill asked while a burst was running
  logic         burst_done;

  assign burst_done = mem_valid && (word_cnt == 6'(`LK_HALF - 1));

  always_ff @(posedge Pclk_Rx or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= FS_IDLE;
      word_cnt      <= '0;
      pending       <= 1'b0;
      fetch_req     <= 1'b0;
      fetch_restart <= 1'b0;
    end
    else
    begin
      fetch_req     <= 1'b0;  // both are single clock pulses
      fetch_restart <= 1'b0;
      if (frame_start)
      begin
        // new frame, logo starts again at word 0
        state         <= FS_FILL_FIRST;
        word_cnt      <= '0;
        pending       <= 1'b0;
        fetch_req     <= 1'b1;
        fetch_restart <= 1'b1;
      end
      else
      begin
        if (mem_valid)
          word_cnt <= burst_done ? '0 : word_cnt + 1'b1;
        case (state)
          FS_IDLE:
            if (refill_need)
            begin
              fetch_req <= 1'b1;
              state     <= FS_REFILL;
            end
          FS_FILL_FIRST:
          begin
            if (refill_need)
              pending <= 1'b1;
            if (burst_done)
            begin
              fetch_req <= 1'b1;  // half 1 follows straight away
              state     <= FS_FILL_SECOND;
            end
          end
          default: // second fill or refill running
            if (burst_done)
            begin
              if (pending || refill_need)
              begin
                fetch_req <= 1'b1;
                pending   <= 1'b0;
                state     <= FS_REFILL;
              end
              else
                state <= FS_IDLE;
            end
            else if (refill_need)
              pending <= 1'b1;
        endcase
      end
    end
  end

  // the memory answers requests only
  a_no_data_idle: assert property (@(posedge Pclk_Rx) disable iff (!reset_n)
    mem_valid |-> state != FS_IDLE);

  // the read side cannot cross two halves within one burst
  a_no_double_refill: assert property (@(posedge Pclk_Rx) disable iff (!reset_n)
    refill_need |-> !pending);

endmodule

/* key_regs.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module key_regs (
  input  logic                    Pclk_Rx,
  input  logic                    reset_n,
  input  logic                    reg_wr,
  input  logo_key_pkg::reg_addr_e reg_addr,
  input  logic [`LK_REG_W-1:0]    reg_data,
  input  logic                    frame_start,
  output logo_key_pkg::window_t   window,
  output logic                    key_enable
);

  import logo_key_pkg::*;

  window_t win_pend;  // written by the cpu at any time
  logic    en_pend;

  always_ff @(posedge Pclk_Rx or negedge reset_n)
  begin
    if (!reset_n)
    begin
      win_pend <= '0;
      en_pend  <= 1'b0;
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        REG_MODE:    en_pend          <= reg_data[0];
        REG_X_START: win_pend.x_start <= reg_data[`LK_X_W-1:0];
        REG_Y_START: win_pend.y_start <= reg_data[`LK_Y_W-1:0];
        REG_X_END:   win_pend.x_end   <= reg_data[`LK_X_W-1:0];
        REG_Y_END:   win_pend.y_end   <= reg_data[`LK_Y_W-1:0];
        default: ;  // unknown address, nothing to write
      endcase
    end
  end

  // ------------------------------
  // active copy, moves only between frames
  // ------------------------------
  always_ff @(posedge Pclk_Rx or negedge reset_n)
  begin
    if (!reset_n)
    begin
      window     <= '0;  // empty window
      key_enable <= 1'b0;
    end
    else if (frame_start)
    begin
      window     <= win_pend;
      key_enable <= en_pend;
    end
  end

  a_reg_wr_known: assert property (@(posedge Pclk_Rx) disable iff (!reset_n)
    !$isunknown(reg_wr));

endmodule

/* raster_counter.sv */
`timescale 1ns/1ps
`include "logo_key_defs.svh"

module raster_counter (
  input  logic                      Pclk_Rx,
  input  logic                      reset_n,
  input  logo_key_pkg::hvf_t        rx_hvf,
  input  logo_key_pkg::window_t     window,
  output logo_key_pkg::raster_pos_t pos,
  output logic                      frame_start,
  output logic                      in_window
);

  logic [`LK_X_W-1:0] x_cnt;
  logic [`LK_Y_W-1:0] y_cnt;
  logic               h_d;  // h one clock back
  logic               v_d;
  logic               x_hit;
  logic               y_hit;

  // ------------------------------
  // position counters
  // ------------------------------
  always_ff @(posedge Pclk_Rx or negedge reset_n)
  begin
    if (!reset_n)
    begin
      x_cnt <= '0;
      y_cnt <= '0;
      h_d   <= 1'b0;
      v_d   <= 1'b0;
    end
    else
    begin
      h_d <= rx_hvf.h;
      v_d <= rx_hvf.v;
      // x reads 0 on the first active clock of the line
      if (rx_hvf.h)
        x_cnt <= '0;
      else
        x_cnt <= x_cnt + 1'b1;
      if (rx_hvf.h && !h_d)  // start of horizontal blanking
      begin
        if (rx_hvf.v)
          y_cnt <= '0;  // lines inside vertical blanking restart at 0
        else
          y_cnt <= y_cnt + 1'b1;
      end
    end
  end

  assign pos.x = x_cnt;
  assign pos.y = y_cnt;

  // first active clock after vertical blanking
  assign frame_start = v_d && !rx_hvf.v;

  // ------------------------------
  // window check
  // ------------------------------
  assign x_hit = (x_cnt >= window.x_start) && (x_cnt < window.x_end);
  assign y_hit = (y_cnt >= window.y_start) && (y_cnt < window.y_end);

  assign in_window = !rx_hvf.h && !rx_hvf.v && x_hit && y_hit;

endmodule

/* logo_key_pkg.sv */
`include "logo_key_defs.svh"

package logo_key_pkg;

  // one logo pixel as it comes from logo memory
  typedef struct packed {
    logic [`LK_BYTE_W-1:0] hi;   // blended into the high sample
    logic [`LK_BYTE_W-1:0] lo;   // blended into the low sample
    logic [`LK_BYTE_W-1:0] key;  // alpha, 0 keeps the video
  } logo_pixel_t;

  typedef struct packed {
    logic [`LK_X_W-1:0] x;
    logic [`LK_Y_W-1:0] y;
  } raster_pos_t;

  // window corners, end values are exclusive
  typedef struct packed {
    logic [`LK_X_W-1:0] x_start;
    logic [`LK_Y_W-1:0] y_start;
    logic [`LK_X_W-1:0] x_end;
    logic [`LK_Y_W-1:0] y_end;
  } window_t;

  typedef struct packed {
    logic [`LK_SAMPLE_W-1:0] hi;
    logic [`LK_SAMPLE_W-1:0] lo;
  } video_word_t;

  // bit 0 is h, as on the receiver pins
  typedef struct packed {
    logic f;
    logic v;
    logic h;
  } hvf_t;

  typedef enum logic [`LK_REG_ADDR_W-1:0] {
    REG_MODE    = 4'd0,
    REG_X_START = 4'd1,
    REG_Y_START = 4'd2,
    REG_X_END   = 4'd3,
    REG_Y_END   = 4'd4
  } reg_addr_e;

  typedef enum logic [2:0] {
    FS_IDLE,
    FS_FILL_FIRST,   // restart burst into half 0
    FS_FILL_SECOND,  // continue burst into half 1
    FS_REFILL        // continue burst during keying
  } fetch_state_e;

endpackage

/* logo_key_defs.svh */
`ifndef LOGO_KEY_DEFS_SVH
`define LOGO_KEY_DEFS_SVH

// ------------------------------
// raster counters
// ------------------------------
`define LK_X_W        12  // pixel counter
`define LK_Y_W        11  // line counter

// ------------------------------
// video and logo data
// ------------------------------
`define LK_SAMPLE_W   10  // one sdi sample, two per word
`define LK_BYTE_W     8   // logo byte and key

// logo ring, refilled one half at a time
`define LK_BUF_DEPTH  96
`define LK_HALF       48  // also the burst length of the logo memory

// register port
`define LK_REG_W      16
`define LK_REG_ADDR_W 4

`define LK_PIPE       2   // keying latency in clocks

`endif
